//--- hw/bank_htu_pkg.sv
`default_nettype none

package bank_htu_pkg;

  // ----------------------------------------------------------
  // geometry and address fields
  // ----------------------------------------------------------
  localparam int NUM_SETS   = 8;
  localparam int NUM_WAYS   = 8;
  localparam int TAG_LSB    = 10;
  localparam int INDEX_LSB  = 5;
  localparam int OFFSET_BIT = 4;

  localparam int INDEX_W = 3;
  localparam int WAY_W   = 3;
  localparam int TAG_W   = 22;

  // bit 1 of a half-line state marks dirty
  typedef enum logic [1:0] {
    ST_EMPTY = 2'b00,
    ST_CLEAN = 2'b01,
    ST_DIRTY = 2'b11
  } line_state_e;

  // address bits 31:4 at their bus positions
  typedef logic [31:OFFSET_BIT] htu_addr_t;
  typedef logic [TAG_W-1:0]     tag_t;
  typedef logic [INDEX_W-1:0]   set_idx_t;
  typedef logic [WAY_W-1:0]     way_t;

  // ----------------------------------------------------------
  // payloads
  // ----------------------------------------------------------
  typedef struct packed {
    logic [1:0] ch_id;
    logic       is_write;
    htu_addr_t  addr;
    logic [7:0] wbuffer_id;
  } htu_req_t;

  typedef struct packed {
    logic        hit;
    logic        need_evit;
    way_t        way;
    line_state_e off0_state;
    line_state_e off1_state;
  } lookup_t;

  // opcode bit 1 is need_evit and bit 0 is write
  typedef struct packed {
    logic [1:0]               ch_id;
    logic [1:0]               opcode;
    logic [INDEX_W+WAY_W:0]   set_way_offset;
    logic [7:0]               wbuffer_id;
    line_state_e              off0_state;
    line_state_e              off1_state;
    logic                     need_linefill;
    set_idx_t                 linefill_set;
    way_t                     linefill_way;
  } isu_req_t;

  typedef struct packed {
    logic [INDEX_W+WAY_W-1:0] set_way;
    logic [31:INDEX_LSB]      araddr;
  } biu_ar_t;

endpackage

`default_nettype wire

//--- hw/bank_htu_set_entry.sv
`timescale 1ns/1ns
`default_nettype none

module bank_htu_set_entry (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  upd_i,
  input  logic                  is_write_i,
  input  bank_htu_pkg::tag_t    tag_i,
  input  logic                  offset_i,
  output bank_htu_pkg::lookup_t lookup_o
);

  bank_htu_pkg::tag_t                 tag_q  [bank_htu_pkg::NUM_WAYS];
  bank_htu_pkg::line_state_e          off0_q [bank_htu_pkg::NUM_WAYS];
  bank_htu_pkg::line_state_e          off1_q [bank_htu_pkg::NUM_WAYS];
  bank_htu_pkg::way_t                 victim_q;
  logic [bank_htu_pkg::NUM_WAYS-1:0]  hit_vec;
  logic                               hit;
  bank_htu_pkg::way_t                 hit_way;
  bank_htu_pkg::way_t                 acc_way;
  bank_htu_pkg::line_state_e          acc_state;
  bank_htu_pkg::line_state_e          new_state;
  logic                               victim_dirty;

  // ----------------------------------------------------------
  // lookup
  // ----------------------------------------------------------
  // a way is live while either half holds data
  always_comb begin
    hit_way = '0;
    for (int w = 0; w < bank_htu_pkg::NUM_WAYS; w++) begin
      hit_vec[w] = (tag_q[w] == tag_i)
                 && ((off0_q[w] != bank_htu_pkg::ST_EMPTY)
                 ||  (off1_q[w] != bank_htu_pkg::ST_EMPTY));
      if (hit_vec[w]) begin
        hit_way = bank_htu_pkg::way_t'(w);
      end
    end
  end

  assign hit     = |hit_vec;
  assign acc_way = hit ? hit_way : victim_q;

  always_comb begin
    if (offset_i) begin
      acc_state = off1_q[acc_way];
    end else begin
      acc_state = off0_q[acc_way];
    end
  end

  always_comb begin
    if (is_write_i) begin
      new_state = bank_htu_pkg::ST_DIRTY;
    end else begin
      new_state = bank_htu_pkg::ST_CLEAN;
    end
  end

  assign victim_dirty = (off0_q[victim_q] == bank_htu_pkg::ST_DIRTY)
                      || (off1_q[victim_q] == bank_htu_pkg::ST_DIRTY);

  always_comb begin
    lookup_o.hit        = hit;
    lookup_o.need_evit  = !hit && victim_dirty;
    lookup_o.way        = acc_way;
    lookup_o.off0_state = off0_q[acc_way];
    lookup_o.off1_state = off1_q[acc_way];
  end

  // ----------------------------------------------------------
  // update on accept
  // ----------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (upd_i && !hit) begin
      tag_q[acc_way] <= tag_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int w = 0; w < bank_htu_pkg::NUM_WAYS; w++) begin
        off0_q[w] <= bank_htu_pkg::ST_EMPTY;
        off1_q[w] <= bank_htu_pkg::ST_EMPTY;
      end
      victim_q <= '0;
    end else if (upd_i) begin
      if (hit) begin
        // read of a clean or dirty half leaves it alone
        if (is_write_i || acc_state == bank_htu_pkg::ST_EMPTY) begin
          if (offset_i) begin
            off1_q[acc_way] <= new_state;
          end else begin
            off0_q[acc_way] <= new_state;
          end
        end
      end else begin
        // victim allocated with the other half empty
        if (offset_i) begin
          off0_q[acc_way] <= bank_htu_pkg::ST_EMPTY;
          off1_q[acc_way] <= new_state;
        end else begin
          off0_q[acc_way] <= new_state;
          off1_q[acc_way] <= bank_htu_pkg::ST_EMPTY;
        end
        victim_q <= victim_q + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/bank_htu_set_array.sv
`timescale 1ns/1ns
`default_nettype none

module bank_htu_set_array (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   kickoff_i,
  input  bank_htu_pkg::htu_req_t req_i,
  output bank_htu_pkg::lookup_t  lookup_o
);

  bank_htu_pkg::set_idx_t            index;
  bank_htu_pkg::tag_t                tag;
  logic                              offset;
  logic [bank_htu_pkg::NUM_SETS-1:0] index_dcd;
  logic [bank_htu_pkg::NUM_SETS-1:0] upd;
  bank_htu_pkg::lookup_t             set_lookup [bank_htu_pkg::NUM_SETS];

  // ----------------------------------------------------------
  // address split
  // ----------------------------------------------------------
  assign index  = req_i.addr[bank_htu_pkg::INDEX_LSB +: bank_htu_pkg::INDEX_W];
  assign tag    = req_i.addr[bank_htu_pkg::TAG_LSB +: bank_htu_pkg::TAG_W];
  assign offset = req_i.addr[bank_htu_pkg::OFFSET_BIT];

  // only the addressed set sees the accept
  assign upd = {bank_htu_pkg::NUM_SETS{kickoff_i}} & index_dcd;

  // ----------------------------------------------------------
  // sets
  // ----------------------------------------------------------
  for (genvar s = 0; s < bank_htu_pkg::NUM_SETS; s++) begin : g_set
    assign index_dcd[s] = (index == bank_htu_pkg::set_idx_t'(s));

    bank_htu_set_entry u_set_entry (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .upd_i      (upd[s]),
      .is_write_i (req_i.is_write),
      .tag_i      (tag),
      .offset_i   (offset),
      .lookup_o   (set_lookup[s])
    );
  end

  // one-hot select of the addressed set
  always_comb begin
    lookup_o = '0;
    for (int s = 0; s < bank_htu_pkg::NUM_SETS; s++) begin
      if (index_dcd[s]) begin
        lookup_o = set_lookup[s];
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/bank_htu_issue.sv
`timescale 1ns/1ns
`default_nettype none

module bank_htu_issue (
  input  logic                   req_valid_i,
  input  bank_htu_pkg::htu_req_t req_i,
  input  bank_htu_pkg::lookup_t  lookup_i,
  input  logic                   isu_allow_in_i,
  input  logic                   ar_ready_i,
  output logic                   req_allow_in_o,
  output logic                   kickoff_o,
  output logic                   isu_valid_o,
  output bank_htu_pkg::isu_req_t isu_req_o,
  output logic                   ar_valid_o,
  output bank_htu_pkg::biu_ar_t  ar_o
);

  bank_htu_pkg::set_idx_t    index;
  logic                      offset;
  bank_htu_pkg::line_state_e acc_state;
  logic                      need_refill;
  logic                      ar_clear;

  assign index  = req_i.addr[bank_htu_pkg::INDEX_LSB +: bank_htu_pkg::INDEX_W];
  assign offset = req_i.addr[bank_htu_pkg::OFFSET_BIT];

  always_comb begin
    if (offset) begin
      acc_state = lookup_i.off1_state;
    end else begin
      acc_state = lookup_i.off0_state;
    end
  end

  // ----------------------------------------------------------
  // handshake
  // ----------------------------------------------------------
  // reads fetch on miss or on an empty half
  assign need_refill = !req_i.is_write
                     && (!lookup_i.hit || acc_state == bank_htu_pkg::ST_EMPTY);

  // linefill read either not needed or taken this cycle
  assign ar_clear = !need_refill || ar_ready_i;

  assign req_allow_in_o = isu_allow_in_i && ar_clear;
  assign kickoff_o      = req_valid_i && req_allow_in_o;
  assign isu_valid_o    = req_valid_i && ar_clear;
  assign ar_valid_o     = req_valid_i && need_refill;

  // ----------------------------------------------------------
  // payloads
  // ----------------------------------------------------------
  always_comb begin
    isu_req_o.ch_id          = req_i.ch_id;
    isu_req_o.opcode         = {lookup_i.need_evit, req_i.is_write};
    isu_req_o.set_way_offset = {index, lookup_i.way, offset};
    isu_req_o.wbuffer_id     = req_i.wbuffer_id;
    isu_req_o.off0_state     = lookup_i.off0_state;
    isu_req_o.off1_state     = lookup_i.off1_state;
    isu_req_o.need_linefill  = need_refill;
    isu_req_o.linefill_set   = index;
    isu_req_o.linefill_way   = lookup_i.way;
  end

  always_comb begin
    ar_o.set_way = {index, lookup_i.way};
    ar_o.araddr  = req_i.addr[31:bank_htu_pkg::INDEX_LSB];
  end

endmodule

`default_nettype wire

//--- hw/bank_htu_top.sv
`timescale 1ns/1ns
`default_nettype none

module bank_htu_top (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  // crossbar request
  input  logic                   req_valid_i,
  input  bank_htu_pkg::htu_req_t req_i,
  output logic                   req_allow_in_o,
  // issue unit
  output logic                   isu_valid_o,
  output bank_htu_pkg::isu_req_t isu_req_o,
  input  logic                   isu_allow_in_i,
  // linefill read toward the bus interface
  output logic                   ar_valid_o,
  output bank_htu_pkg::biu_ar_t  ar_o,
  input  logic                   ar_ready_i
);

  logic                  kickoff;
  bank_htu_pkg::lookup_t lookup;

  // ----------------------------------------------------------
  // tag store
  // ----------------------------------------------------------
  bank_htu_set_array u_set_array (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .kickoff_i (kickoff),
    .req_i     (req_i),
    .lookup_o  (lookup)
  );

  // ----------------------------------------------------------
  // issue stage
  // ----------------------------------------------------------
  // kickoff feeds back only into state
  bank_htu_issue u_issue (
    .req_valid_i    (req_valid_i),
    .req_i          (req_i),
    .lookup_i       (lookup),
    .isu_allow_in_i (isu_allow_in_i),
    .ar_ready_i     (ar_ready_i),
    .req_allow_in_o (req_allow_in_o),
    .kickoff_o      (kickoff),
    .isu_valid_o    (isu_valid_o),
    .isu_req_o      (isu_req_o),
    .ar_valid_o     (ar_valid_o),
    .ar_o           (ar_o)
  );

endmodule

`default_nettype wire

//--- sim/bank_htu_chk.sv
`timescale 1ns/1ns
`default_nettype none

module bank_htu_chk (
  input logic clk_i,
  input logic rst_n_i,
  input logic req_valid_i,
  input logic req_allow_in_i,
  input logic isu_valid_i,
  input logic isu_allow_in_i,
  input logic ar_valid_i,
  input logic ar_ready_i
);

  int unsigned fail_cnt = 0;

  // linefill read only for a live request
  ar_needs_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ar_valid_i |-> req_valid_i)
    else begin
      fail_cnt <= fail_cnt + 1;
      $error("ar_valid_o high without req_valid_i");
    end

  // a stalled linefill holds the issue side back
  refill_stall: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (ar_valid_i && !ar_ready_i) |-> !isu_valid_i)
    else begin
      fail_cnt <= fail_cnt + 1;
      $error("isu_valid_o high while linefill read is stalled");
    end

  allow_needs_isu: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_allow_in_i |-> isu_allow_in_i)
    else begin
      fail_cnt <= fail_cnt + 1;
      $error("req_allow_in_o high without isu_allow_in_i");
    end

endmodule

bind bank_htu_top bank_htu_chk bank_htu_chk_inst (
  .clk_i          (clk_i),
  .rst_n_i        (rst_n_i),
  .req_valid_i    (req_valid_i),
  .req_allow_in_i (req_allow_in_o),
  .isu_valid_i    (isu_valid_o),
  .isu_allow_in_i (isu_allow_in_i),
  .ar_valid_i     (ar_valid_o),
  .ar_ready_i     (ar_ready_i)
);

`default_nettype wire

//--- sim/bank_htu_tb.sv
`timescale 1ns/1ns
`default_nettype none

module bank_htu_tb;

  localparam int TIMEOUT = 100;

  logic                   clk_i;
  logic                   rst_n_i;
  logic                   req_valid_i;
  bank_htu_pkg::htu_req_t req_i;
  logic                   req_allow_in_o;
  logic                   isu_valid_o;
  bank_htu_pkg::isu_req_t isu_req_o;
  logic                   isu_allow_in_i;
  logic                   ar_valid_o;
  bank_htu_pkg::biu_ar_t  ar_o;
  logic                   ar_ready_i;

  // tag store model indexed by set, way and offset bit
  bank_htu_pkg::tag_t        m_tag    [bank_htu_pkg::NUM_SETS][bank_htu_pkg::NUM_WAYS];
  bank_htu_pkg::line_state_e m_half   [bank_htu_pkg::NUM_SETS][bank_htu_pkg::NUM_WAYS][2];
  bank_htu_pkg::way_t        m_victim [bank_htu_pkg::NUM_SETS];

  // outputs seen in the first cycle of the last request
  bank_htu_pkg::isu_req_t snap_isu;
  bank_htu_pkg::biu_ar_t  snap_ar;
  logic                   snap_isu_valid;
  logic                   snap_ar_valid;
  logic                   snap_allow;

  int          err_cnt;
  int          test_cnt;
  int          test_err_base;
  int unsigned seed;

  bank_htu_top bank_htu_top_inst (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .req_valid_i    (req_valid_i),
    .req_i          (req_i),
    .req_allow_in_o (req_allow_in_o),
    .isu_valid_o    (isu_valid_o),
    .isu_req_o      (isu_req_o),
    .isu_allow_in_i (isu_allow_in_i),
    .ar_valid_o     (ar_valid_o),
    .ar_o           (ar_o),
    .ar_ready_i     (ar_ready_i)
  );

  initial begin
    clk_i = 1'b0;
    forever begin
      #2 clk_i = ~clk_i;
    end
  end

  // ----------------------------------------------------------
  // reference model
  // ----------------------------------------------------------
  function automatic void clear_store();
    for (int s = 0; s < bank_htu_pkg::NUM_SETS; s++) begin
      m_victim[s] = '0;
      for (int w = 0; w < bank_htu_pkg::NUM_WAYS; w++) begin
        m_tag[s][w]     = '0;
        m_half[s][w][0] = bank_htu_pkg::ST_EMPTY;
        m_half[s][w][1] = bank_htu_pkg::ST_EMPTY;
      end
    end
  endfunction

  function automatic bank_htu_pkg::lookup_t expected_lookup(bank_htu_pkg::htu_req_t r);
    bank_htu_pkg::lookup_t lk;
    int s;
    int v;
    s = r.addr[7:5];
    lk = '0;
    lk.way = m_victim[s];
    for (int w = 0; w < bank_htu_pkg::NUM_WAYS; w++) begin
      if (m_tag[s][w] == r.addr[31:10] && (m_half[s][w][0] != bank_htu_pkg::ST_EMPTY
          || m_half[s][w][1] != bank_htu_pkg::ST_EMPTY)) begin
        lk.hit = 1'b1;
        lk.way = w;
      end
    end
    v = lk.way;
    if (!lk.hit) begin
      lk.need_evit = (m_half[s][v][0] == bank_htu_pkg::ST_DIRTY)
                  || (m_half[s][v][1] == bank_htu_pkg::ST_DIRTY);
    end
    lk.off0_state = m_half[s][v][0];
    lk.off1_state = m_half[s][v][1];
    return lk;
  endfunction

  function automatic logic needs_refill(bank_htu_pkg::htu_req_t r, bank_htu_pkg::lookup_t lk);
    bank_htu_pkg::line_state_e half;
    half = r.addr[4] ? lk.off1_state : lk.off0_state;
    return !r.is_write && (!lk.hit || half == bank_htu_pkg::ST_EMPTY);
  endfunction

  function automatic void apply_update(bank_htu_pkg::htu_req_t r);
    bank_htu_pkg::lookup_t lk;
    int s;
    int w;
    int h;
    lk = expected_lookup(r);
    s = r.addr[7:5];
    w = lk.way;
    h = r.addr[4];
    if (lk.hit) begin
      if (r.is_write) begin
        m_half[s][w][h] = bank_htu_pkg::ST_DIRTY;
      end else if (m_half[s][w][h] == bank_htu_pkg::ST_EMPTY) begin
        m_half[s][w][h] = bank_htu_pkg::ST_CLEAN;
      end
    end else begin
      m_tag[s][w]         = r.addr[31:10];
      m_half[s][w][h]     = r.is_write ? bank_htu_pkg::ST_DIRTY : bank_htu_pkg::ST_CLEAN;
      m_half[s][w][1 - h] = bank_htu_pkg::ST_EMPTY;
      m_victim[s]         = m_victim[s] + 1'b1;
    end
  endfunction

  function automatic void flag_mismatch(string what, logic [63:0] got, logic [63:0] exp);
    err_cnt++;
    $display("ERR %0t: %s got %0h exp %0h", $time, what, got, exp);
  endfunction

  // ----------------------------------------------------------
  // comparison at the falling edge
  // ----------------------------------------------------------
  initial begin : compare
    bank_htu_pkg::lookup_t  lk;
    bank_htu_pkg::isu_req_t exp_isu;
    bank_htu_pkg::biu_ar_t  exp_ar;
    bank_htu_pkg::htu_req_t acc_req;
    logic                   refill;
    logic                   exp_allow;
    logic                   exp_isu_valid;
    logic                   exp_ar_valid;
    logic                   accept;
    forever begin
      @(negedge clk_i);
      accept = 1'b0;
      if (!rst_n_i) begin
        clear_store();
      end else begin
        lk            = expected_lookup(req_i);
        refill        = needs_refill(req_i, lk);
        exp_allow     = isu_allow_in_i && (!refill || ar_ready_i);
        exp_isu_valid = req_valid_i && (!refill || ar_ready_i);
        exp_ar_valid  = req_valid_i && refill;
        exp_isu.ch_id          = req_i.ch_id;
        exp_isu.opcode         = {lk.need_evit, req_i.is_write};
        exp_isu.set_way_offset = {req_i.addr[7:5], lk.way, req_i.addr[4]};
        exp_isu.wbuffer_id     = req_i.wbuffer_id;
        exp_isu.off0_state     = lk.off0_state;
        exp_isu.off1_state     = lk.off1_state;
        exp_isu.need_linefill  = refill;
        exp_isu.linefill_set   = req_i.addr[7:5];
        exp_isu.linefill_way   = lk.way;
        exp_ar.set_way         = {req_i.addr[7:5], lk.way};
        exp_ar.araddr          = req_i.addr[31:5];
        if (isu_valid_o !== exp_isu_valid) flag_mismatch("isu_valid_o", isu_valid_o, exp_isu_valid);
        if (ar_valid_o !== exp_ar_valid) flag_mismatch("ar_valid_o", ar_valid_o, exp_ar_valid);
        if (req_allow_in_o !== exp_allow) flag_mismatch("req_allow_in_o", req_allow_in_o, exp_allow);
        if (req_valid_i && isu_req_o !== exp_isu) flag_mismatch("isu_req_o", isu_req_o, exp_isu);
        if (req_valid_i && ar_o !== exp_ar) flag_mismatch("ar_o", ar_o, exp_ar);
        accept  = req_valid_i && exp_allow;
        acc_req = req_i;
      end
      @(posedge clk_i);
      if (accept) begin
        apply_update(acc_req);
      end
    end
  end

  // ----------------------------------------------------------
  // stimulus
  // ----------------------------------------------------------
  function automatic bank_htu_pkg::htu_req_t make_req(logic wr, bank_htu_pkg::tag_t tag,
                                                      int set, logic off);
    bank_htu_pkg::htu_req_t r;
    logic [31:0]            a;
    a        = '0;
    a[31:10] = tag;
    a[7:5]   = set[2:0];
    a[4]     = off;
    r.ch_id      = tag[1:0];
    r.is_write   = wr;
    r.addr       = a[31:4];
    r.wbuffer_id = {tag[3:0], set[3:0]};
    return r;
  endfunction

  function automatic void capture();
    snap_isu       = isu_req_o;
    snap_ar        = ar_o;
    snap_isu_valid = isu_valid_o;
    snap_ar_valid  = ar_valid_o;
    snap_allow     = req_allow_in_o;
  endfunction

  // holds the request until accepted with optional random ready levels
  task automatic send(bank_htu_pkg::htu_req_t r, bit rand_ready);
    int n;
    bit done;
    n    = 0;
    done = 1'b0;
    req_valid_i <= 1'b1;
    req_i       <= r;
    while (!done && n < TIMEOUT) begin
      if (rand_ready) begin
        isu_allow_in_i <= ($urandom % 4) != 0;
        ar_ready_i     <= ($urandom % 4) != 0;
      end
      @(negedge clk_i);
      if (n == 0) begin
        capture();
      end
      done = req_allow_in_o;
      n++;
      @(posedge clk_i);
    end
    if (!done) begin
      $display("timeout: request to set %0d not accepted in %0d cycles", r.addr[7:5], TIMEOUT);
      $display("FAIL: see errors above");
      $finish;
    end
  endtask

  // one cycle of a request that is not expected to be taken
  task automatic probe(bank_htu_pkg::htu_req_t r);
    req_valid_i <= 1'b1;
    req_i       <= r;
    @(negedge clk_i);
    capture();
    @(posedge clk_i);
  endtask

  task automatic idle(int cycles);
    req_valid_i <= 1'b0;
    repeat (cycles) @(posedge clk_i);
  endtask

  function automatic void begin_test();
    test_err_base = err_cnt;
  endfunction

  function automatic void end_test(string name);
    test_cnt++;
    $display("test %0d %s: %0d errors", test_cnt, name, err_cnt - test_err_base);
  endfunction

  // ----------------------------------------------------------
  // tests
  // ----------------------------------------------------------
  initial begin : main
    bank_htu_pkg::tag_t     t_a;
    bank_htu_pkg::htu_req_t r;
    seed           = $urandom(75);
    err_cnt        = 0;
    test_cnt       = 0;
    rst_n_i        = 1'b0;
    req_valid_i    = 1'b0;
    req_i          = '0;
    isu_allow_in_i = 1'b1;
    ar_ready_i     = 1'b1;
    repeat (2) @(posedge clk_i);
    rst_n_i <= 1'b1;

    begin_test();
    t_a = 22'h12345;
    send(make_req(1'b0, t_a, 3, 1'b0), 1'b0);
    if (snap_isu.need_linefill !== 1'b1) flag_mismatch("need_linefill", snap_isu.need_linefill, 1);
    if (snap_ar_valid !== 1'b1) flag_mismatch("ar_valid_o", snap_ar_valid, 1);
    if (snap_isu.linefill_way !== 3'd0) flag_mismatch("way", snap_isu.linefill_way, 0);
    if (snap_isu.opcode[1] !== 1'b0) flag_mismatch("need_evit", snap_isu.opcode[1], 0);
    if (snap_ar.araddr !== {t_a, 2'b00, 3'd3}) flag_mismatch("araddr", snap_ar.araddr,
                                                             {t_a, 2'b00, 3'd3});
    end_test("reset read miss");

    begin_test();
    send(make_req(1'b0, t_a, 3, 1'b0), 1'b0);
    if (snap_isu.need_linefill !== 1'b0) flag_mismatch("need_linefill", snap_isu.need_linefill, 0);
    if (snap_ar_valid !== 1'b0) flag_mismatch("ar_valid_o", snap_ar_valid, 0);
    if (snap_isu.off0_state !== bank_htu_pkg::ST_CLEAN) flag_mismatch("off0_state",
                                                          snap_isu.off0_state, 1);
    send(make_req(1'b0, t_a, 3, 1'b1), 1'b0);
    if (snap_isu.linefill_way !== 3'd0) flag_mismatch("way", snap_isu.linefill_way, 0);
    if (snap_isu.need_linefill !== 1'b1) flag_mismatch("need_linefill", snap_isu.need_linefill, 1);
    end_test("read hit and empty half");

    begin_test();
    send(make_req(1'b1, t_a, 3, 1'b1), 1'b0);
    if (snap_isu.need_linefill !== 1'b0) flag_mismatch("need_linefill", snap_isu.need_linefill, 0);
    send(make_req(1'b0, t_a, 3, 1'b0), 1'b0);
    if (snap_isu.off1_state !== bank_htu_pkg::ST_DIRTY) flag_mismatch("off1_state",
                                                          snap_isu.off1_state, 3);
    send(make_req(1'b1, 22'h0abcd, 3, 1'b0), 1'b0);
    if (snap_ar_valid !== 1'b0) flag_mismatch("ar_valid_o", snap_ar_valid, 0);
    if (snap_isu.linefill_way !== 3'd1) flag_mismatch("way", snap_isu.linefill_way, 1);
    end_test("write hit and write miss");

    begin_test();
    for (int i = 0; i < 9; i++) begin
      send(make_req(1'b1, 22'h200 + i, 5, i % 2), 1'b0);
      if (snap_isu.linefill_way !== 3'(i % 8)) flag_mismatch("way", snap_isu.linefill_way, i % 8);
      if (snap_isu.opcode[1] !== (i == 8)) flag_mismatch("need_evit", snap_isu.opcode[1], i == 8);
    end
    end_test("round-robin eviction");

    begin_test();
    isu_allow_in_i <= 1'b0;
    repeat (3) begin
      probe(make_req(1'b1, 22'h300, 6, 1'b0));
      if (snap_allow !== 1'b0) flag_mismatch("req_allow_in_o", snap_allow, 0);
      if (snap_isu.off0_state !== bank_htu_pkg::ST_EMPTY) flag_mismatch("off0_state",
                                                            snap_isu.off0_state, 0);
    end
    isu_allow_in_i <= 1'b1;
    send(make_req(1'b1, 22'h300, 6, 1'b0), 1'b0);
    if (snap_isu.linefill_way !== 3'd0) flag_mismatch("way", snap_isu.linefill_way, 0);
    if (snap_isu.off0_state !== bank_htu_pkg::ST_EMPTY) flag_mismatch("off0_state",
                                                          snap_isu.off0_state, 0);
    ar_ready_i <= 1'b0;
    repeat (2) begin
      probe(make_req(1'b0, 22'h301, 7, 1'b1));
      if (snap_ar_valid !== 1'b1) flag_mismatch("ar_valid_o", snap_ar_valid, 1);
      if (snap_isu_valid !== 1'b0) flag_mismatch("isu_valid_o", snap_isu_valid, 0);
      if (snap_allow !== 1'b0) flag_mismatch("req_allow_in_o", snap_allow, 0);
    end
    ar_ready_i <= 1'b1;
    send(make_req(1'b0, 22'h301, 7, 1'b1), 1'b0);
    if (snap_isu.linefill_way !== 3'd0) flag_mismatch("way", snap_isu.linefill_way, 0);
    end_test("back-pressure");

    begin_test();
    repeat (300) begin
      r = make_req($urandom % 2, $urandom % 12, $urandom % 8, $urandom % 2);
      r.ch_id      = $urandom;
      r.wbuffer_id = $urandom;
      send(r, 1'b1);
      if ($urandom % 8 == 0) idle(1);
    end
    isu_allow_in_i <= 1'b1;
    ar_ready_i     <= 1'b1;
    end_test("random traffic");

    idle(2);
    err_cnt += bank_htu_top_inst.bank_htu_chk_inst.fail_cnt;
    $display("tests run: %0d, errors: %0d", test_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- bank_htu.f
hw/bank_htu_pkg.sv
hw/bank_htu_set_entry.sv
hw/bank_htu_set_array.sv
hw/bank_htu_issue.sv
hw/bank_htu_top.sv
sim/bank_htu_chk.sv
sim/bank_htu_tb.sv

//--- Bender.yml
package:
  name: bank_htu

sources:
  # design
  - files:
      - hw/bank_htu_pkg.sv
      - hw/bank_htu_set_entry.sv
      - hw/bank_htu_set_array.sv
      - hw/bank_htu_issue.sv
      - hw/bank_htu_top.sv
  # testbench and bound checks
  - target: simulation
    files:
      - sim/bank_htu_chk.sv
      - sim/bank_htu_tb.sv
